//--- compile.f
verilog/l1_cache_pkg.sv
verilog/cache_addr_decode.sv
verilog/cache_controller.sv
verilog/cache_frame_store.sv
verilog/cache_response.sv
verilog/l1_cache.sv
verification/mem_model.sv
verification/l1_cache_assertions.sv
verification/l1_cache_tb.sv

//--- verification/l1_cache_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the L1 cache with a stalling memory
// stimulus addresses must stay inside the memory map
// of mem_model (1 KB at 0 and at 0xF0000000)
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module l1_cache_tb;
    import l1_cache_pkg::*;

    localparam logic [1:0] OP_RD  = 2'd0;
    localparam logic [1:0] OP_WR  = 2'd1;
    localparam logic [1:0] OP_FL  = 2'd2;
    localparam logic [1:0] OP_LOG = 2'd3;
    localparam int MEM_WORDS    = 512;
    // up to three stall cycles plus the completing cycle
    localparam int WORD_CYCLES  = 4;
    localparam int MISS_CYCLES  = 2 * BLOCK_WORDS * WORD_CYCLES + 4;
    localparam int FLUSH_CYCLES = N_SETS * (BLOCK_WORDS * WORD_CYCLES + 1) + 4;

    typedef struct packed {
        logic [1:0] op;
        word_t      addr;
        word_t      data;
        byte_en_t   be;
        logic       miss;
    } entry_t;

    logic        CLK = 1'b0;
    logic        nRST;
    logic        ren;
    logic        wen;
    logic        flush;
    word_t       addr;
    word_t       wdata;
    byte_en_t    byte_en;
    word_t       rdata;
    logic        busy;
    logic        mem_ren;
    logic        mem_wen;
    logic        mem_busy;
    word_t       mem_addr;
    word_t       mem_wdata;
    word_t       mem_rdata;
    byte_en_t    mem_byte_en;
    logic        flush_done;
    logic [31:0] misses;
    logic [1:0]  stall_len;

    entry_t      stim [$];
    word_t       shadow [MEM_WORDS];
    logic [31:0] lfsr_state = 32'h77e1_c248;
    word_t       wdata_stall;
    int          err_cnt;
    int          check_cnt;
    int          flush_cnt;
    int          flush_sent;
    int          n_flush;
    int          cycle_cnt;
    int          cycle_limit;

    l1_cache #(
        .NONCACHE_START(DEFAULT_NONCACHE_START)
    ) UUT (
        .CLK        (CLK),
        .nRST       (nRST),
        .ren        (ren),
        .wen        (wen),
        .addr       (addr),
        .wdata      (wdata),
        .byte_en    (byte_en),
        .flush      (flush),
        .mem_busy   (mem_busy),
        .mem_rdata  (mem_rdata),
        .rdata      (rdata),
        .busy       (busy),
        .mem_ren    (mem_ren),
        .mem_wen    (mem_wen),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_byte_en(mem_byte_en),
        .flush_done (flush_done),
        .misses     (misses)
    );

    mem_model u_mem (
        .CLK      (CLK),
        .nRST     (nRST),
        .ren      (mem_ren),
        .wen      (mem_wen),
        .addr     (mem_addr),
        .wdata    (mem_wdata),
        .byte_en  (mem_byte_en),
        .stall_len(stall_len),
        .busy     (mem_busy),
        .rdata    (mem_rdata)
    );

    always #5 CLK = ~CLK;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0000_0000);
    endfunction

    // one LFSR step per bit taken
    task automatic take_bits(input int n, output word_t v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    function automatic int slot_of(input word_t a);
        return {a[28], a[9:2]};
    endfunction

    function automatic word_t merge_lanes(input word_t old, input word_t nw, input byte_en_t be);
        word_t r;
        r = old;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                r[8*i +: 8] = nw[8*i +: 8];
            end
        end
        return r;
    endfunction

    task automatic check_equal(input word_t got, input word_t exp, input string what);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic add_entry(input logic [1:0] op, input word_t a, input word_t d,
                             input byte_en_t be, input logic miss);
        stim.push_back(entry_t'{op, a, d, be, miss});
        if (op == OP_FL) begin
            n_flush++;
        end
    endtask

    task automatic load_table();
        add_entry(OP_RD,  32'h0000_0000, 32'h0,          4'hF,    1'b1);
        add_entry(OP_RD,  32'h0000_0004, 32'h0,          4'hF,    1'b0);
        add_entry(OP_RD,  32'h0000_0000, 32'h0,          4'hF,    1'b0);
        add_entry(OP_WR,  32'h0000_0008, 32'hAABB_CCDD,  4'b0001, 1'b1);
        add_entry(OP_RD,  32'h0000_0008, 32'h0,          4'hF,    1'b0);
        add_entry(OP_WR,  32'h0000_000C, 32'h1122_3344,  4'b1100, 1'b0);
        add_entry(OP_RD,  32'h0000_000C, 32'h0,          4'hF,    1'b0);
        add_entry(OP_WR,  32'h0000_0010, 32'hDEAD_BEEF,  4'hF,    1'b1);
        add_entry(OP_WR,  32'h0000_0014, 32'h0BAD_F00D,  4'hF,    1'b0);
        // same index, other tag, so the dirty block goes back
        add_entry(OP_RD,  32'h0000_0110, 32'h0,          4'hF,    1'b1);
        add_entry(OP_LOG, 32'h0000_0010, 32'hDEAD_BEEF,  4'hF,    1'b0);
        add_entry(OP_LOG, 32'h0000_0014, 32'h0BAD_F00D,  4'hF,    1'b0);
        add_entry(OP_RD,  32'h0000_0010, 32'h0,          4'hF,    1'b1);
        add_entry(OP_WR,  32'hF000_0000, 32'h5566_7788,  4'b0110, 1'b0);
        add_entry(OP_LOG, 32'hF000_0000, 32'h0066_7700,  4'hF,    1'b0);
        add_entry(OP_RD,  32'hF000_0000, 32'h0,          4'hF,    1'b0);
        add_entry(OP_RD,  32'hF000_0004, 32'h0,          4'hF,    1'b0);
        add_entry(OP_WR,  32'h0000_0020, 32'h1234_5678,  4'hF,    1'b1);
        add_entry(OP_FL,  32'h0000_0000, 32'h0,          4'h0,    1'b0);
        add_entry(OP_RD,  32'h0000_0020, 32'h0,          4'hF,    1'b1);
        add_entry(OP_RD,  32'h0000_0008, 32'h0,          4'hF,    1'b1);
        add_entry(OP_RD,  32'h0000_0010, 32'h0,          4'hF,    1'b1);
    endtask

    // starts and ends 1 ns after a rising edge
    task automatic run_access(input entry_t e);
        int          slot;
        logic [31:0] misses_before;
        slot = slot_of(e.addr);
        misses_before = misses;
        ren = (e.op == OP_RD);
        wen = (e.op == OP_WR);
        addr = e.addr;
        wdata = e.data;
        byte_en = e.be;
        do begin
            @(negedge CLK);
        end while (busy);
        if (e.op == OP_RD) begin
            check_equal(rdata, shadow[slot], $sformatf("read data at %h", e.addr));
        end else begin
            shadow[slot] = merge_lanes(shadow[slot], e.data, e.be);
        end
        check_equal(misses - misses_before, 32'(e.miss),
                    $sformatf("miss count step at %h", e.addr));
        @(posedge CLK);
        #1;
        ren = 1'b0;
        wen = 1'b0;
    endtask

    task automatic run_flush();
        flush = 1'b1;
        flush_sent++;
        @(posedge CLK);
        #1;
        flush = 1'b0;
        do begin
            @(negedge CLK);
        end while (!flush_done);
        @(posedge CLK);
        #1;
        check_equal(flush_cnt, flush_sent, "flush_done pulse count");
    endtask

    // newest write to that address in the memory write log
    task automatic find_logged_write(input word_t a, input word_t exp);
        int    found;
        word_t got;
        found = 0;
        got = '0;
        for (int k = u_mem.log_addr.size() - 1; k >= 0 && found == 0; k--) begin
            if (u_mem.log_addr[k] == a) begin
                found = 1;
                got = u_mem.log_data[k];
            end
        end
        if (found == 0) begin
            err_cnt++;
            $display("ERROR %0t: no memory write was logged for address %h", $time, a);
        end else begin
            check_equal(got, exp, $sformatf("logged write at %h", a));
        end
    endtask

    task automatic compare_memory();
        for (int s = 0; s < MEM_WORDS; s++) begin
            check_equal(u_mem.mem[s], shadow[s], $sformatf("memory word in slot %0d", s));
        end
    endtask

    always @(posedge CLK) begin
        #1;
        take_bits(2, wdata_stall);
        stall_len = wdata_stall[1:0];
    end

    always @(negedge CLK) begin
        if (flush_done) begin
            flush_cnt++;
        end
    end

    always @(posedge CLK) begin
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit) begin
            $display("ERROR: the run hung, no response from the cache within %0d cycles",
                     cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        entry_t e;
        nRST = 1'b0;
        ren = 1'b0;
        wen = 1'b0;
        flush = 1'b0;
        addr = '0;
        wdata = '0;
        byte_en = '0;
        stall_len = 2'd0;
        load_table();
        cycle_limit = N_SETS + 10 + stim.size() * MISS_CYCLES + n_flush * FLUSH_CYCLES;
        for (int s = 0; s < MEM_WORDS; s++) begin
            take_bits(32, shadow[s]);
            u_mem.mem[s] = shadow[s];
        end
        repeat (3) @(posedge CLK);
        #1;
        nRST = 1'b1;
        // the first request simply waits out the reset sweep
        foreach (stim[i]) begin
            e = stim[i];
            case (e.op)
                OP_RD, OP_WR: run_access(e);
                OP_FL: run_flush();
                default: find_logged_write(e.addr, e.data);
            endcase
        end
        repeat (4) @(posedge CLK);
        check_equal(flush_cnt, flush_sent, "total flush_done pulses");
        compare_memory();
        $display("errors: %0d in %0d checks", err_cnt, check_cnt);
        if (err_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/l1_cache_assertions.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus protocol rules of the cache controller
// bound into every cache_controller instance
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module l1_cache_assertions (
    input wire logic                      CLK,
    input wire logic                      nRST,
    input wire logic                      busy,
    input wire l1_cache_pkg::ctrl_state_e state,
    input wire logic                      mem_ren,
    input wire logic                      mem_wen,
    input wire logic                      mem_busy,
    input wire l1_cache_pkg::word_t       mem_addr,
    input wire logic                      flush_done
);
    import l1_cache_pkg::*;

    no_dual_strobe: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_ren && mem_wen))
        else $error("mem_ren and mem_wen are high in the same cycle");

    flush_done_single: assert property (@(posedge CLK) disable iff (!nRST)
        flush_done |=> !flush_done)
        else $error("flush_done is longer than one cycle");

    // a stalled write-back word keeps its address
    wb_addr_stable: assert property (@(posedge CLK) disable iff (!nRST)
        (state == WRITE_BACK && mem_busy) |=> $stable(mem_addr))
        else $error("mem_addr changed during a stalled write-back");

    sweep_busy: assert property (@(posedge CLK) disable iff (!nRST)
        (state == SWEEP) |-> busy)
        else $error("busy is low during the reset sweep");

endmodule

bind cache_controller l1_cache_assertions u_assert (
    .CLK       (CLK),
    .nRST      (nRST),
    .busy      (busy),
    .state     (state),
    .mem_ren   (mem_ren),
    .mem_wen   (mem_wen),
    .mem_busy  (mem_busy),
    .mem_addr  (mem_addr),
    .flush_done(flush_done)
);

`default_nettype wire

//--- verification/mem_model.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// word memory for the cache memory bus
// only addr[28] and addr[9:2] select a word, so the
// map covers 1 KB at 0 and 1 KB at 0xF0000000
// stall length comes from the testbench each cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module mem_model (
    input  wire logic                   CLK,
    input  wire logic                   nRST,
    input  wire logic                   ren,
    input  wire logic                   wen,
    input  wire l1_cache_pkg::word_t    addr,
    input  wire l1_cache_pkg::word_t    wdata,
    input  wire l1_cache_pkg::byte_en_t byte_en,
    input  wire logic [1:0]             stall_len,
    output logic                        busy,
    output l1_cache_pkg::word_t         rdata
);
    import l1_cache_pkg::*;

    localparam int MEM_WORDS = 512;

    word_t      mem [MEM_WORDS];
    word_t      log_addr [$];
    word_t      log_data [$];
    logic [1:0] wait_cnt;
    logic [8:0] slot;

    assign slot  = {addr[28], addr[9:2]};
    // data only while a read is on the bus
    assign rdata = ren ? mem[slot] : 'x;
    assign busy  = (ren || wen) && (wait_cnt != 2'd0);

    // each access waits the stall loaded when the previous one ended
    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            wait_cnt <= 2'd0;
        end else if ((ren || wen) && wait_cnt != 2'd0) begin
            wait_cnt <= wait_cnt - 2'd1;
        end else if (ren || wen) begin
            wait_cnt <= stall_len;
            if (wen) begin
                for (int i = 0; i < 4; i++) begin
                    if (byte_en[i]) begin
                        mem[slot][8*i +: 8] <= wdata[8*i +: 8];
                    end
                end
                // raw bus word, before lane masking
                log_addr.push_back(addr);
                log_data.push_back(wdata);
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/l1_cache.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// direct-mapped write-back L1 data cache
// processor holds ren/wen and operands until busy is low
// busy is high for N_SETS cycles after reset
// memory side serves one word at a time, no handshake
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module l1_cache #(
    parameter l1_cache_pkg::word_t NONCACHE_START = l1_cache_pkg::DEFAULT_NONCACHE_START
) (
    input  wire logic                   CLK,
    input  wire logic                   nRST,
    input  wire logic                   ren,
    input  wire logic                   wen,
    input  wire l1_cache_pkg::word_t    addr,
    input  wire l1_cache_pkg::word_t    wdata,
    input  wire l1_cache_pkg::byte_en_t byte_en,
    input  wire logic                   flush,
    input  wire logic                   mem_busy,
    input  wire l1_cache_pkg::word_t    mem_rdata,
    output l1_cache_pkg::word_t         rdata,
    output logic                        busy,
    output logic                        mem_ren,
    output logic                        mem_wen,
    output l1_cache_pkg::word_t         mem_addr,
    output l1_cache_pkg::word_t         mem_wdata,
    output l1_cache_pkg::byte_en_t      mem_byte_en,
    output logic                        flush_done,
    output logic [31:0]                 misses
);
    import l1_cache_pkg::*;

    logic [SET_W-1:0]  req_index;
    logic [OFFS_W-1:0] req_offset;
    logic [TAG_W-1:0]  req_tag;
    logic              hit;
    logic              pass_through;
    logic              victim_dirty;

    logic              rd_valid;
    logic              rd_dirty;
    logic [TAG_W-1:0]  rd_tag;
    word_t             rd_word;

    ctrl_state_e       state;
    logic [SET_W-1:0]  store_index;
    logic [OFFS_W-1:0] store_offset;
    logic              store_we;
    byte_en_t          store_byte_mask;
    logic              store_sel_mem;
    logic              store_set_valid;
    logic              store_set_dirty;
    logic              store_clear;

    cache_addr_decode #(
        .NONCACHE_START(NONCACHE_START)
    ) u_decode (
        .addr        (addr),
        .rd_valid    (rd_valid),
        .rd_dirty    (rd_dirty),
        .rd_tag      (rd_tag),
        .req_index   (req_index),
        .req_offset  (req_offset),
        .req_tag     (req_tag),
        .hit         (hit),
        .pass_through(pass_through),
        .victim_dirty(victim_dirty)
    );

    cache_controller u_ctrl (
        .CLK            (CLK),
        .nRST           (nRST),
        .ren            (ren),
        .wen            (wen),
        .byte_en        (byte_en),
        .flush          (flush),
        .hit            (hit),
        .pass_through   (pass_through),
        .victim_dirty   (victim_dirty),
        .req_index      (req_index),
        .req_offset     (req_offset),
        .req_tag        (req_tag),
        .rd_tag         (rd_tag),
        .mem_busy       (mem_busy),
        .busy           (busy),
        .state          (state),
        .store_index    (store_index),
        .store_offset   (store_offset),
        .store_we       (store_we),
        .store_byte_mask(store_byte_mask),
        .store_sel_mem  (store_sel_mem),
        .store_set_valid(store_set_valid),
        .store_set_dirty(store_set_dirty),
        .store_clear    (store_clear),
        .mem_ren        (mem_ren),
        .mem_wen        (mem_wen),
        .mem_addr       (mem_addr),
        .mem_byte_en    (mem_byte_en),
        .flush_done     (flush_done),
        .misses         (misses)
    );

    cache_frame_store u_store (
        .CLK      (CLK),
        .nRST     (nRST),
        .index    (store_index),
        .offset   (store_offset),
        .we       (store_we),
        .byte_mask(store_byte_mask),
        .wdata    (wdata),
        .sel_mem  (store_sel_mem),
        .mem_rdata(mem_rdata),
        .set_valid(store_set_valid),
        .set_dirty(store_set_dirty),
        .clear    (store_clear),
        .new_tag  (req_tag),
        .rd_valid (rd_valid),
        .rd_dirty (rd_dirty),
        .rd_tag   (rd_tag),
        .rd_word  (rd_word)
    );

    cache_response u_resp (
        .state       (state),
        .pass_through(pass_through),
        .byte_en     (byte_en),
        .wdata       (wdata),
        .rd_word     (rd_word),
        .mem_rdata   (mem_rdata),
        .rdata       (rdata),
        .mem_wdata   (mem_wdata)
    );

endmodule

`default_nettype wire

//--- verilog/cache_response.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// read data and memory write data paths
// pass-through writes carry only the enabled lanes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module cache_response (
    input  wire l1_cache_pkg::ctrl_state_e state,
    input  wire logic                      pass_through,
    input  wire l1_cache_pkg::byte_en_t    byte_en,
    input  wire l1_cache_pkg::word_t       wdata,
    input  wire l1_cache_pkg::word_t       rd_word,
    input  wire l1_cache_pkg::word_t       mem_rdata,
    output l1_cache_pkg::word_t            rdata,
    output l1_cache_pkg::word_t            mem_wdata
);
    import l1_cache_pkg::*;

    word_t lane_wdata;

    // zero every lane that byte_en leaves off
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            lane_wdata[8*i +: 8] = byte_en[i] ? wdata[8*i +: 8] : 8'h00;
        end
    end

    assign rdata = pass_through ? mem_rdata : rd_word;

    // write-back and flush send the stored word
    assign mem_wdata = (state == READY && pass_through) ? lane_wdata : rd_word;

endmodule

`default_nettype wire

//--- verilog/cache_frame_store.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// frame storage: tag, valid, dirty and block data
// reads are combinational at index/offset
// writes land at the clock edge after we or clear
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module cache_frame_store (
    input  wire logic                             CLK,
    input  wire logic                             nRST,
    input  wire logic [l1_cache_pkg::SET_W-1:0]   index,
    input  wire logic [l1_cache_pkg::OFFS_W-1:0]  offset,
    input  wire logic                             we,
    input  wire l1_cache_pkg::byte_en_t           byte_mask,
    input  wire l1_cache_pkg::word_t              wdata,
    input  wire logic                             sel_mem,
    input  wire l1_cache_pkg::word_t              mem_rdata,
    input  wire logic                             set_valid,
    input  wire logic                             set_dirty,
    input  wire logic                             clear,
    input  wire logic [l1_cache_pkg::TAG_W-1:0]   new_tag,
    output logic                                  rd_valid,
    output logic                                  rd_dirty,
    output logic [l1_cache_pkg::TAG_W-1:0]        rd_tag,
    output l1_cache_pkg::word_t                   rd_word
);
    import l1_cache_pkg::*;

    logic [N_SETS-1:0] valid_q;
    logic [N_SETS-1:0] dirty_q;
    logic [TAG_W-1:0]  tag_mem  [N_SETS];
    word_t             data_mem [N_SETS][BLOCK_WORDS];
    word_t             wr_word;

    // refill data from memory, hit data from the processor
    assign wr_word = sel_mem ? mem_rdata : wdata;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (clear) begin
            valid_q[index] <= 1'b0;
            dirty_q[index] <= 1'b0;
        end else if (we) begin
            valid_q[index] <= set_valid;
            dirty_q[index] <= set_dirty;
        end
    end

    always_ff @(posedge CLK) begin
        if (we) begin
            tag_mem[index] <= new_tag;
            for (int i = 0; i < 4; i++) begin
                if (byte_mask[i]) begin
                    data_mem[index][offset][8*i +: 8] <= wr_word[8*i +: 8];
                end
            end
        end
    end

    assign rd_valid = valid_q[index];
    assign rd_dirty = dirty_q[index];
    assign rd_tag   = tag_mem[index];
    assign rd_word  = data_mem[index][offset];

endmodule

`default_nettype wire

//--- verilog/cache_controller.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cache FSM: sweep, hits, write-back, refill, flush
// a pending flush wins over any new request in READY
// mem_busy stalls hold the current word and address
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module cache_controller (
    input  wire logic                             CLK,
    input  wire logic                             nRST,
    input  wire logic                             ren,
    input  wire logic                             wen,
    input  wire l1_cache_pkg::byte_en_t           byte_en,
    input  wire logic                             flush,
    input  wire logic                             hit,
    input  wire logic                             pass_through,
    input  wire logic                             victim_dirty,
    input  wire logic [l1_cache_pkg::SET_W-1:0]   req_index,
    input  wire logic [l1_cache_pkg::OFFS_W-1:0]  req_offset,
    input  wire logic [l1_cache_pkg::TAG_W-1:0]   req_tag,
    input  wire logic [l1_cache_pkg::TAG_W-1:0]   rd_tag,
    input  wire logic                             mem_busy,
    output logic                                  busy,
    output l1_cache_pkg::ctrl_state_e             state,
    output logic [l1_cache_pkg::SET_W-1:0]        store_index,
    output logic [l1_cache_pkg::OFFS_W-1:0]       store_offset,
    output logic                                  store_we,
    output l1_cache_pkg::byte_en_t                store_byte_mask,
    output logic                                  store_sel_mem,
    output logic                                  store_set_valid,
    output logic                                  store_set_dirty,
    output logic                                  store_clear,
    output logic                                  mem_ren,
    output logic                                  mem_wen,
    output l1_cache_pkg::word_t                   mem_addr,
    output l1_cache_pkg::byte_en_t                mem_byte_en,
    output logic                                  flush_done,
    output logic [31:0]                           misses
);
    import l1_cache_pkg::*;

    localparam logic [SET_W-1:0]  LAST_SET  = SET_W'(N_SETS - 1);
    localparam logic [OFFS_W-1:0] LAST_WORD = OFFS_W'(BLOCK_WORDS - 1);

    ctrl_state_e       next_state;
    logic [SET_W-1:0]  set_cnt;
    logic [OFFS_W-1:0] word_cnt;
    logic              flush_req;
    logic              set_step;
    logic              word_step;
    logic              count_miss;
    cache_addr_u       blk_addr;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state     <= SWEEP;
            set_cnt   <= '0;
            word_cnt  <= '0;
            flush_req <= 1'b0;
            misses    <= '0;
        end else begin
            state <= next_state;
            if (set_step) begin
                set_cnt <= set_cnt + 1'b1;
            end
            // wraps back to word 0 after the last word of a block
            if (word_step) begin
                word_cnt <= word_cnt + 1'b1;
            end
            flush_req <= (state == FLUSH) ? 1'b0 : (flush_req || flush);
            if (count_miss) begin
                misses <= misses + 1'b1;
            end
        end
    end

    // sweep and flush walk the sets, everything else uses the request
    assign store_index  = (state == SWEEP || state == FLUSH) ? set_cnt : req_index;
    assign store_offset = (state == READY) ? req_offset : word_cnt;

    // victim tag while writing back, request tag otherwise
    always_comb begin
        blk_addr.f.tag      = (state == WRITE_BACK || state == FLUSH) ? rd_tag : req_tag;
        blk_addr.f.index    = store_index;
        blk_addr.f.offset   = store_offset;
        blk_addr.f.byte_sel = 2'b00;
    end

    assign mem_addr = blk_addr.raw;

    always_comb begin
        next_state      = state;
        busy            = 1'b1;
        store_we        = 1'b0;
        store_byte_mask = '1;
        store_sel_mem   = 1'b0;
        store_set_valid = 1'b0;
        store_set_dirty = 1'b0;
        store_clear     = 1'b0;
        mem_ren         = 1'b0;
        mem_wen         = 1'b0;
        mem_byte_en     = '1;
        flush_done      = 1'b0;
        set_step        = 1'b0;
        word_step       = 1'b0;
        count_miss      = 1'b0;

        case (state)
            SWEEP: begin
                store_clear = 1'b1;
                set_step    = 1'b1;
                if (set_cnt == LAST_SET) begin
                    next_state = READY;
                end
            end
            READY: begin
                if (flush || flush_req) begin
                    next_state = FLUSH;
                end else if (ren || wen) begin
                    if (pass_through) begin
                        mem_ren     = ren;
                        mem_wen     = wen;
                        mem_byte_en = byte_en;
                        busy        = mem_busy;
                    end else if (hit) begin
                        busy            = 1'b0;
                        store_we        = wen;
                        store_byte_mask = byte_en;
                        store_set_valid = 1'b1;
                        store_set_dirty = 1'b1;
                    end else begin
                        count_miss = 1'b1;
                        next_state = victim_dirty ? WRITE_BACK : REFILL;
                    end
                end
            end
            WRITE_BACK: begin
                mem_wen = 1'b1;
                if (!mem_busy) begin
                    word_step = 1'b1;
                    if (word_cnt == LAST_WORD) begin
                        next_state = REFILL;
                    end
                end
            end
            REFILL: begin
                mem_ren = 1'b1;
                if (!mem_busy) begin
                    word_step     = 1'b1;
                    store_we      = 1'b1;
                    store_sel_mem = 1'b1;
                    // frame turns valid with the last word only
                    store_set_valid = (word_cnt == LAST_WORD);
                    if (word_cnt == LAST_WORD) begin
                        next_state = READY;
                    end
                end
            end
            FLUSH: begin
                if (victim_dirty) begin
                    mem_wen = 1'b1;
                    if (!mem_busy) begin
                        word_step = 1'b1;
                        if (word_cnt == LAST_WORD) begin
                            store_clear = 1'b1;
                            set_step    = 1'b1;
                        end
                    end
                end else begin
                    store_clear = 1'b1;
                    set_step    = 1'b1;
                end
                if (set_step && set_cnt == LAST_SET) begin
                    flush_done = 1'b1;
                    next_state = READY;
                end
            end
            default: begin
                next_state = SWEEP;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/cache_addr_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// request address decode and tag compare
// purely combinational; hit is never set on pass-through
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module cache_addr_decode #(
    parameter l1_cache_pkg::word_t NONCACHE_START = l1_cache_pkg::DEFAULT_NONCACHE_START
) (
    input  wire l1_cache_pkg::word_t              addr,
    input  wire logic                             rd_valid,
    input  wire logic                             rd_dirty,
    input  wire logic [l1_cache_pkg::TAG_W-1:0]   rd_tag,
    output logic [l1_cache_pkg::SET_W-1:0]        req_index,
    output logic [l1_cache_pkg::OFFS_W-1:0]       req_offset,
    output logic [l1_cache_pkg::TAG_W-1:0]        req_tag,
    output logic                                  hit,
    output logic                                  pass_through,
    output logic                                  victim_dirty
);
    import l1_cache_pkg::*;

    cache_addr_u req_addr;

    assign req_addr.raw = addr;

    assign req_index  = req_addr.f.index;
    assign req_offset = req_addr.f.offset;
    assign req_tag    = req_addr.f.tag;

    // uncached window at the top of the map
    assign pass_through = (addr >= NONCACHE_START);

    assign hit = !pass_through && rd_valid && (rd_tag == req_addr.f.tag);

    // resident frame has to go back to memory before reuse
    assign victim_dirty = rd_valid && rd_dirty;

endmodule

`default_nettype wire

//--- verilog/l1_cache_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types for the direct-mapped L1 cache
// geometry is fixed here, since the address union needs
// fixed field widths; block size must be a power of two
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package l1_cache_pkg;

    localparam int WORD_W      = 32;
    localparam int CACHE_BYTES = 256;
    localparam int BLOCK_WORDS = 2;
    localparam int N_SETS      = CACHE_BYTES / (BLOCK_WORDS * 4);
    localparam int SET_W       = $clog2(N_SETS);
    localparam int OFFS_W      = $clog2(BLOCK_WORDS);
    localparam int TAG_W       = WORD_W - SET_W - OFFS_W - 2;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [3:0]        byte_en_t;

    // one bus address, seen raw or split into cache fields
    typedef union packed {
        word_t raw;
        struct packed {
            logic [TAG_W-1:0]  tag;
            logic [SET_W-1:0]  index;
            logic [OFFS_W-1:0] offset;
            logic [1:0]        byte_sel;
        } f;
    } cache_addr_u;

    typedef enum logic [2:0] {
        SWEEP,
        READY,
        WRITE_BACK,
        REFILL,
        FLUSH
    } ctrl_state_e;

    // everything at or above this goes straight to memory
    localparam word_t DEFAULT_NONCACHE_START = 32'hF000_0000;

endpackage

`default_nettype wire
